// ==== src.f ====
+incdir+rtl
rtl/mem_pkg.sv
rtl/bus_request_decoder.sv
rtl/segment_map.sv
rtl/sram_access_control.sv
rtl/mem_unit_top.sv
verification/sram_model.sv
verification/mem_unit_checker.sv
verification/mem_unit_tb.sv

// ==== Makefile ====
# Verilator build and run for the memory unit testbench.

VERILATOR ?= verilator
TOP       ?= mem_unit_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= All checks passed

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(wildcard rtl/*.sv rtl/*.svh verification/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# pass only if the testbench printed its pass line.
run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/mem_unit_testdata.hex ====
// columns: op(1) nb(1) ad(4) rdt(4) exp(4), positive logic, one operation per line
// op 0 wr, 1 rd, 2 cfg, 3 rd no answer, 4 wr no answer, 5 wr random, 6 cfg no answer, 7 rd vs ref
// fixed segments 1 and 0
001010A5A50000
1010100000A5A5
0000205A5A0000
10002000005A5A
// unmapped segment 3, page 0 must stay intact
40302012340000
30302000000000
10002000005A5A
// map 03 and 14 to phys 5, 07 to module 1 seg 2
2000A130000000
2000A140010000
20004370000000
003100BEEF0000
1141000000BEEF
014104CAFE0000
1031040000CAFE
// refused configs: segment 1, segment 0, no memory flag
6000A110000000
6000C100000000
6000A080000000
30800000000000
1010100000A5A5
10002000005A5A
// random writes over configured segments
50320000000000
50720000000000
51420800000000
507FFF00000000
503ABC00000000
514ABD00000000
// read back, partly through the alias
71420000000000
707FFF00000000
70320800000000
70720000000000
714ABC00000000
703ABD00000000

// ==== verification/mem_unit_tb.sv ====
/*
	Testbench for the memory unit. Replays bus operations from
	the testdata file against a map model and a reference memory.
*/

`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_unit_tb;
	import mem_pkg::*;

	localparam int MAX_OPS = 64;
	localparam int TIMEOUT = 50; // cycles per wait on ok_n.

	logic        clk;
	logic        rst_n;
	logic [0:3]  nb_n;
	logic [0:15] ad_n;
	logic [0:15] rdt_n;
	logic        rd_n;
	logic        wr_n;
	logic        cfg_n;
	wire  [0:15] ddt_n;
	wire         ok_n;
	wire         sram_ce_n;
	wire         sram_oe_n;
	wire         sram_we_n;
	wire         sram_ub_n;
	wire         sram_lb_n;
	sram_addr_t  sram_a;
	wire  [15:0] sram_d;

	logic [55:0] ops [0:MAX_OPS-1]; // op, nb, ad, rdt, expected.
	phys_t       map_model [0:255];
	word_t       ref_mem [int];     // sparse reference keyed by SRAM address.
	integer      seed;
	int          errors;
	int          tests;

	mem_unit_top mem_unit_top_i (
		.clk(clk), .rst_n(rst_n), .nb_n(nb_n), .ad_n(ad_n), .rdt_n(rdt_n),
		.rd_n(rd_n), .wr_n(wr_n), .cfg_n(cfg_n), .ddt_n(ddt_n), .ok_n(ok_n),
		.sram_ce_n(sram_ce_n), .sram_oe_n(sram_oe_n), .sram_we_n(sram_we_n),
		.sram_ub_n(sram_ub_n), .sram_lb_n(sram_lb_n), .sram_a(sram_a),
		.sram_d(sram_d)
	);

	sram_model sram_model_i (
		.sram_ce_n(sram_ce_n), .sram_oe_n(sram_oe_n), .sram_we_n(sram_we_n),
		.sram_ub_n(sram_ub_n), .sram_lb_n(sram_lb_n), .sram_a(sram_a),
		.sram_d(sram_d)
	);

	bind mem_unit_top mem_unit_checker mem_unit_checker_i (
		.clk(clk), .rst_n(rst_n), .rd_n(rd_n), .wr_n(wr_n), .cfg_n(cfg_n),
		.ok_n(ok_n), .ddt_n(ddt_n), .sram_oe_n(sram_oe_n), .sram_we_n(sram_we_n)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period.
	end

	// hard limit on the whole run.
	initial begin
		#2_000_000;
		$display("simulation ran past its time limit");
		$display("Checks failed");
		$finish;
	end

	// ------------------------------
	// model helpers
	// ------------------------------
	// fixed segments always answer, others need a nonzero entry.
	function automatic logic seg_mapped(input seg_t s);
		return (s < 8'd2) || (map_model[s] != 8'h00);
	endfunction

	function automatic int phys_addr(input seg_t s, input offset_t off);
		return int'({map_model[s][5:0], off}); // page then offset.
	endfunction

	// one strobe cycle on the bus. answered tells whether ok_n came.
	task automatic run_strobe(input int kind, input logic [3:0] nb, input word_t ad,
			input word_t rdt, output logic answered, output word_t rdata);
		int wait_cnt;
		begin
			@(posedge clk);
			#5;
			nb_n  = ~nb;
			ad_n  = ~ad;   // value msb lands on bus bit 0.
			rdt_n = ~rdt;
			@(posedge clk);
			#5;
			case (kind)
				0: rd_n = 1'b0;
				1: wr_n = 1'b0;
				default: cfg_n = 1'b0;
			endcase
			answered = 1'b0;
			rdata    = '0;
			wait_cnt = 0;
			while (!answered && wait_cnt < TIMEOUT) begin
				@(posedge clk);
				#5;
				wait_cnt++;
				if (!ok_n) begin
					answered = 1'b1;
					rdata    = ~ddt_n; // read word while the reply is up.
				end
			end
			rd_n  = 1'b1;
			wr_n  = 1'b1;
			cfg_n = 1'b1;
			wait_cnt = 0;
			while (!ok_n && wait_cnt < TIMEOUT) begin
				@(posedge clk);
				#5;
				wait_cnt++;
			end
			if (!ok_n) begin
				$display("ok_n stayed low after the strobe was released at %0t", $time);
				errors++;
			end
		end
	endtask

	// bus must be quiet before the next request.
	task automatic check_idle_bus(output logic good);
		begin
			good = 1'b1;
			repeat (2) @(posedge clk);
			#5;
			if (ok_n !== 1'b1) begin
				$display("Fail at %0t: ok_n not high between requests", $time);
				good = 1'b0;
			end
			if (ddt_n !== 16'hffff) begin
				$display("Fail at %0t: ddt_n %h not all ones between reads", $time, ddt_n);
				good = 1'b0;
			end
		end
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		logic [3:0] op;
		logic [3:0] nb;
		word_t      ad;
		word_t      rdt;
		word_t      exp_word;
		word_t      wdata;
		word_t      rdata;
		seg_t       seg;
		seg_t       log_seg;
		phys_t      phy;
		int         kind;
		int         pa;
		logic       expect_ok;
		logic       predicted;
		logic       answered;
		logic       good;
		logic       idle_good;

		rst_n  = 1'b0;
		nb_n   = '1;
		ad_n   = '1;
		rdt_n  = '1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		cfg_n  = 1'b1;
		seed   = 6175;
		errors = 0;
		tests  = 0;
		for (int i = 0; i < 256; i++) begin
			map_model[i] = 8'h00;
		end
		map_model[1] = 8'h01;
		for (int i = 0; i < MAX_OPS; i++) begin
			ops[i] = '1; // op F ends the list.
		end
		$readmemh("verification/mem_unit_testdata.hex", ops);

		repeat (16) @(posedge clk);
		#5;
		rst_n = 1'b1;

		for (int i = 0; i < MAX_OPS && ops[i][55:52] != 4'hf; i++) begin
			op       = ops[i][55:52];
			nb       = ops[i][51:48];
			ad       = ops[i][47:32];
			rdt      = ops[i][31:16];
			exp_word = ops[i][15:0];
			seg      = {nb, ad[15:12]};
			log_seg  = {rdt[3:0], rdt[15:12]};  // block, then segment.
			phy      = {ad[4:1], ad[8:5]};      // module, then segment.
			good     = 1'b1;
			tests++;

			// 0 rd, 1 wr, 2 cfg.
			if (op == 4'h1 || op == 4'h3 || op == 4'h7) kind = 0;
			else if (op == 4'h2 || op == 4'h6) kind = 2;
			else kind = 1;
			expect_ok = !(op == 4'h3 || op == 4'h4 || op == 4'h6);
			if (kind == 2) predicted = ad[0] && (log_seg >= 8'd2);
			else predicted = seg_mapped(seg);
			if (predicted != expect_ok) begin
				$display("test data line %0d disagrees with the map model", i);
				good = 1'b0;
			end

			wdata = (op == 4'h5) ? word_t'($random(seed)) : rdt;
			pa    = phys_addr(seg, ad[11:0]);
			run_strobe(kind, nb, ad, wdata, answered, rdata);

			if (answered != expect_ok) begin
				$display("Fail at %0t: answer %0b, expected %0b", $time, answered, expect_ok);
				good = 1'b0;
			end
			if (answered && kind == 1) begin
				ref_mem[pa] = wdata;
			end
			if (answered && kind == 2) begin
				map_model[log_seg] = phy;
			end
			if (answered && kind == 0) begin
				if (!ref_mem.exists(pa)) begin
					$display("test data reads address %h that was never written", pa);
					good = 1'b0;
				end else if (rdata != ref_mem[pa]) begin
					$display("Fail at %0t: read %h, reference %h", $time, rdata, ref_mem[pa]);
					good = 1'b0;
				end
				if (op == 4'h1 && rdata != exp_word) begin
					$display("Fail at %0t: read %h, expected %h", $time, rdata, exp_word);
					good = 1'b0;
				end
			end

			check_idle_bus(idle_good);
			if (!good || !idle_good) errors++;
			$display("test %0d op %h seg %h: %s", i, op, seg, (good && idle_good) ? "ok" : "error");
		end

		// bound assertion failures count against the run as well.
		errors += mem_unit_top_i.mem_unit_checker_i.fail_count;
		$display("%0d tests, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== verification/mem_unit_checker.sv ====
/*
	Bus and SRAM pin assertions for the memory unit,
	bound onto the top level.
*/

`timescale 1ns/1ps

module mem_unit_checker (
	input logic        clk,
	input logic        rst_n,
	input logic        rd_n,
	input logic        wr_n,
	input logic        cfg_n,
	input logic        ok_n,
	input logic [0:15] ddt_n,
	input logic        sram_oe_n,
	input logic        sram_we_n
);

	logic any_strobe;
	int   fail_count; // assertion failures seen so far.

	assign any_strobe = !rd_n || !wr_n || !cfg_n; // some master strobe active.

	// ------------------------------
	// reply
	// ------------------------------
	ok_after_reset: assert property (@(posedge clk) !rst_n |=> ok_n)
		else begin
			$error("ok_n low right after reset");
			fail_count = fail_count + 1;
		end

	// reply only with a strobe held or shortly after its release.
	ok_only_with_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		!ok_n |-> (any_strobe || $past(any_strobe) || $past(any_strobe, 2)))
		else begin
			$error("ok_n low without a strobe");
			fail_count = fail_count + 1;
		end

	// read data bus idles high once rd_n has been released a clock.
	ddt_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(rd_n && $past(rd_n)) |-> (ddt_n == '1))
		else begin
			$error("ddt_n driven without a read");
			fail_count = fail_count + 1;
		end

	// ------------------------------
	// SRAM pins
	// ------------------------------
	oe_we_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(!sram_oe_n && !sram_we_n))
		else begin
			$error("sram_oe_n and sram_we_n low together");
			fail_count = fail_count + 1;
		end

endmodule

// ==== verification/sram_model.sv ====
/*
	Behavioral asynchronous 256K x 16 SRAM.
	Level-sensitive write, tristate read data.
*/

`timescale 1ns/1ps
`include "mem_settings.svh"

module sram_model (
	input  logic                    sram_ce_n,
	input  logic                    sram_oe_n,
	input  logic                    sram_we_n,
	input  logic                    sram_ub_n,
	input  logic                    sram_lb_n,
	input  logic [`MEM_SRAM_AW-1:0] sram_a,
	inout  wire  [`MEM_WORD_W-1:0]  sram_d
);

	localparam int DEPTH = 1 << `MEM_SRAM_AW;

	logic [`MEM_WORD_W-1:0] mem [0:DEPTH-1];

	// fill from the whole address so stray reads stand out.
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = 16'(i) ^ 16'(i >> 2);
		end
	end

	// read drives the bus only while output enabled and not writing.
	assign sram_d = (!sram_ce_n && !sram_oe_n && sram_we_n) ? mem[sram_a] : 'z;

	// write follows data while we_n is low, last value wins.
	always @* begin
		if (!sram_ce_n && !sram_we_n) begin
			if (!sram_lb_n) mem[sram_a][7:0]  = sram_d[7:0];   // low lane.
			if (!sram_ub_n) mem[sram_a][15:8] = sram_d[15:8];  // high lane.
		end
	end

endmodule

// ==== rtl/mem_unit_top.sv ====
/*
	Configurable memory unit for an Elwro-type bus.
	Decoder, segment map and SRAM control in a three-stage chain.
*/

`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_unit_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [0:3]             nb_n,
	input  logic [0:`MEM_WORD_W-1] ad_n,
	input  logic [0:`MEM_WORD_W-1] rdt_n,
	input  logic                   rd_n,
	input  logic                   wr_n,
	input  logic                   cfg_n,
	output logic [0:`MEM_WORD_W-1] ddt_n,
	output logic                   ok_n,
	output logic                   sram_ce_n,
	output logic                   sram_oe_n,
	output logic                   sram_we_n,
	output logic                   sram_ub_n,
	output logic                   sram_lb_n,
	output mem_pkg::sram_addr_t    sram_a,
	inout  wire [`MEM_WORD_W-1:0]  sram_d
);
	import mem_pkg::*;

	// ------------------------------
	// stage 1 to stage 2/3
	// ------------------------------
	logic    req_rd;
	logic    req_wr;
	logic    req_cfg;
	seg_t    seg;
	offset_t offset;
	word_t   wdata;
	seg_t    cfg_log;
	phys_t   cfg_phy;
	logic    cfg_mem;

	// stage 2 to stage 3.
	phys_t   map_entry;
	logic    seg_fixed;
	logic    cfg_done;

	bus_request_decoder bus_request_decoder_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.nb_n    (nb_n),
		.ad_n    (ad_n),
		.rdt_n   (rdt_n),
		.rd_n    (rd_n),
		.wr_n    (wr_n),
		.cfg_n   (cfg_n),
		.req_rd  (req_rd),
		.req_wr  (req_wr),
		.req_cfg (req_cfg),
		.seg     (seg),
		.offset  (offset),
		.wdata   (wdata),
		.cfg_log (cfg_log),
		.cfg_phy (cfg_phy),
		.cfg_mem (cfg_mem)
	);

	segment_map segment_map_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.seg       (seg),
		.req_cfg   (req_cfg),
		.cfg_mem   (cfg_mem),
		.cfg_log   (cfg_log),
		.cfg_phy   (cfg_phy),
		.map_entry (map_entry),
		.seg_fixed (seg_fixed),
		.cfg_done  (cfg_done)
	);

	sram_access_control sram_access_control_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_rd    (req_rd),
		.req_wr    (req_wr),
		.req_cfg   (req_cfg),
		.map_entry (map_entry),
		.seg_fixed (seg_fixed),
		.offset    (offset),
		.wdata     (wdata),
		.cfg_done  (cfg_done),
		.ok_n      (ok_n),
		.ddt_n     (ddt_n),
		.sram_ce_n (sram_ce_n),
		.sram_oe_n (sram_oe_n),
		.sram_we_n (sram_we_n),
		.sram_ub_n (sram_ub_n),
		.sram_lb_n (sram_lb_n),
		.sram_a    (sram_a),
		.sram_d    (sram_d)
	);

endmodule

// ==== rtl/sram_access_control.sv ====
/*
	SRAM access control, stage 3.
	Checks the translated page, runs one asynchronous SRAM
	cycle and forms the ok_n reply and ddt_n read data.
*/

`timescale 1ns/1ps
`include "mem_settings.svh"

module sram_access_control (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   req_rd,
	input  logic                   req_wr,
	input  logic                   req_cfg,
	input  mem_pkg::phys_t         map_entry,
	input  logic                   seg_fixed,
	input  mem_pkg::offset_t       offset,
	input  mem_pkg::word_t         wdata,
	input  logic                   cfg_done,
	output logic                   ok_n,
	output logic [0:`MEM_WORD_W-1] ddt_n,
	output logic                   sram_ce_n,
	output logic                   sram_oe_n,
	output logic                   sram_we_n,
	output logic                   sram_ub_n,
	output logic                   sram_lb_n,
	output mem_pkg::sram_addr_t    sram_a,
	inout  wire [`MEM_WORD_W-1:0]  sram_d
);
	import mem_pkg::*;

	acc_state_t state;
	logic       oe;       // output enable, positive logic.
	logic       we;       // write enable, positive logic.
	logic       ok;       // access finished, reply pending.
	logic       unmapped;
	word_t      rd_data;

	// chip and both byte lanes always on.
	assign sram_ce_n = 1'b0;
	assign sram_ub_n = 1'b0;
	assign sram_lb_n = 1'b0;
	assign sram_oe_n = ~oe;
	assign sram_we_n = ~we;

	// data lines driven only inside a write cycle.
	assign sram_d = we ? wdata : 'z;

	// ------------------------------
	// bus reply
	// ------------------------------
	// access reply while a strobe is held, config reply from the map stage.
	assign ok_n  = ~((ok && (req_rd || req_wr)) || (cfg_done && req_cfg));
	assign ddt_n = (ok && req_rd) ? ~rd_data : '1; // idle bus reads as all ones.

	// non-fixed segment with a zero entry has no memory behind it.
	assign unmapped = !seg_fixed && (map_entry == '0);

	// ------------------------------
	// access FSM
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= acc_idle;
			oe    <= 1'b0;
			we    <= 1'b0;
			ok    <= 1'b0;
		end else begin
			case (state)
				acc_idle: begin
					if (req_rd || req_wr) begin
						state <= acc_map; // map_entry for this seg is ready next cycle.
					end
				end
				acc_map: begin
					if (unmapped) begin
						state <= acc_idle; // no reply, master times out.
					end else if (req_rd) begin
						oe    <= 1'b1;
						state <= acc_read;
					end else if (req_wr) begin
						we    <= 1'b1;
						state <= acc_write;
					end else begin
						state <= acc_idle; // strobe dropped early.
					end
				end
				acc_read: begin
					oe    <= 1'b0;     // data captured on this edge.
					ok    <= 1'b1;
					state <= acc_ok;
				end
				acc_write: begin
					we    <= 1'b0;     // single-cycle write pulse.
					ok    <= 1'b1;
					state <= acc_ok;
				end
				acc_ok: begin
					// wait for both request levels to drop.
					if (!req_rd && !req_wr) begin
						ok    <= 1'b0;
						state <= acc_idle;
					end
				end
				default: begin
					state <= acc_idle;
				end
			endcase
		end
	end

	// address latched at the map check, read word at the end of the read cycle.
	always_ff @(posedge clk) begin
		if (state == acc_map) begin
			sram_a <= {map_entry[`MEM_PAGE_W-1:0], offset}; // page then offset.
		end
		if (state == acc_read) begin
			rd_data <= sram_d;
		end
	end

endmodule

// ==== rtl/segment_map.sv ====
/*
	Segment map, stage 2.
	256-entry logical-to-physical table with a registered
	lookup port and a FSM that loads entries on config strobes.
*/

`timescale 1ns/1ps
`include "mem_settings.svh"

module segment_map (
	input  logic           clk,
	input  logic           rst_n,
	input  mem_pkg::seg_t  seg,       // lookup address, valid every cycle.
	input  logic           req_cfg,
	input  logic           cfg_mem,
	input  mem_pkg::seg_t  cfg_log,
	input  mem_pkg::phys_t cfg_phy,
	output mem_pkg::phys_t map_entry,
	output logic           seg_fixed,
	output logic           cfg_done
);
	import mem_pkg::*;

	localparam int MAP_DEPTH = 1 << `MEM_SEG_W;

	phys_t      map_ram [0:MAP_DEPTH-1]; // block RAM, one write port, one read port.
	cfg_state_t cfg_state;
	logic       cfg_accept;
	logic       map_we;

	// ------------------------------
	// power-up contents
	// ------------------------------
	// segment 1 points at physical 1, everything else starts unmapped.
	// entry 0 stays zero but seg_fixed covers it.
	initial begin
		for (int i = 0; i < MAP_DEPTH; i++) begin
			map_ram[i] = '0;
		end
		map_ram[1] = phys_t'(1);
	end

	// ------------------------------
	// map RAM
	// ------------------------------
	assign map_we = (cfg_state == cfg_write); // one write per accepted strobe.

	always_ff @(posedge clk) begin
		if (map_we) begin
			map_ram[cfg_log] <= cfg_phy;
		end
		map_entry <= map_ram[seg];                          // registered read.
		seg_fixed <= (seg < seg_t'(`MEM_FIXED_SEGS));     // kept aligned with map_entry.
	end

	// ------------------------------
	// configuration FSM
	// ------------------------------
	// refuse words without the memory flag and any write to a fixed segment.
	assign cfg_accept = req_cfg && cfg_mem && (cfg_log >= seg_t'(`MEM_FIXED_SEGS));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cfg_state <= cfg_idle;
		end else begin
			case (cfg_state)
				cfg_idle: begin
					if (cfg_accept) begin
						cfg_state <= cfg_write;
					end
				end
				cfg_write: begin
					cfg_state <= cfg_ack; // entry lands on this edge.
				end
				cfg_ack: begin
					// hold the acknowledge until the master lets go.
					if (!req_cfg) begin
						cfg_state <= cfg_idle;
					end
				end
				default: begin
					cfg_state <= cfg_idle;
				end
			endcase
		end
	end

	assign cfg_done = (cfg_state == cfg_ack); // decoded from a flop, glitch free.

endmodule

// ==== rtl/bus_request_decoder.sv ====
/*
	Bus request decoder, stage 1.
	Samples the active-low bus lines once per clock and
	hands a registered positive-logic request to the map stage.
*/

`timescale 1ns/1ps
`include "mem_settings.svh"

module bus_request_decoder (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [0:3]            nb_n,  // block number, bit 0 is msb.
	input  logic [0:`MEM_WORD_W-1] ad_n,
	input  logic [0:`MEM_WORD_W-1] rdt_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic                  cfg_n,
	output logic                  req_rd,
	output logic                  req_wr,
	output logic                  req_cfg,
	output mem_pkg::seg_t         seg,
	output mem_pkg::offset_t      offset,
	output mem_pkg::word_t        wdata,
	output mem_pkg::seg_t         cfg_log,
	output mem_pkg::phys_t        cfg_phy,
	output logic                  cfg_mem
);
	import mem_pkg::*;

	seg_t    seg_in;  // de-inverted lines ahead of the register.
	offset_t off_in;
	word_t   wdata_in;
	seg_t    log_in;
	phys_t   phy_in;

	// ------------------------------
	// de-inversion and field reorder
	// ------------------------------
	assign seg_in   = ~{nb_n, ad_n[0:3]};                 // logical segment of the access.
	assign off_in   = ~ad_n[4:15];
	assign wdata_in = ~rdt_n;                              // bus bit 0 lands on bit 15.
	// config word: rdt carries the logical side, ad the physical side.
	assign log_in   = ~{rdt_n[12:15], rdt_n[0:3]};         // block, then segment.
	assign phy_in   = ~{ad_n[11:14], ad_n[7:10]};          // module, then segment.

	// request levels, cleared on reset.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			req_rd  <= 1'b0;
			req_wr  <= 1'b0;
			req_cfg <= 1'b0;
		end else begin
			req_rd  <= ~rd_n;  // held as a level while the strobe is low.
			req_wr  <= ~wr_n;
			req_cfg <= ~cfg_n;
		end
	end

	// payload follows the bus every clock.
	always_ff @(posedge clk) begin
		seg     <= seg_in;
		offset  <= off_in;
		wdata   <= wdata_in;
		cfg_log <= log_in;
		cfg_phy <= phy_in;
		cfg_mem <= ~ad_n[15]; // memory flag, last bit of the config word.
	end

endmodule

// ==== rtl/mem_pkg.sv ====
/*
	Memory unit types: positive-logic vectors
	and the state encodings of both FSMs.
*/

`include "mem_settings.svh"

package mem_pkg;

	// ------------------------------
	// data and address vectors
	// ------------------------------
	typedef logic [`MEM_WORD_W-1:0]   word_t;      // data word, positive logic.
	typedef logic [`MEM_SEG_W-1:0]    seg_t;       // nb[0:3] then segment bits.
	typedef logic [`MEM_SEG_W-1:0]    phys_t;      // module[3:0] then phys segment.
	typedef logic [`MEM_OFFSET_W-1:0] offset_t;    // word inside a segment.
	typedef logic [`MEM_SRAM_AW-1:0]  sram_addr_t; // page then offset.

	// ------------------------------
	// FSM encodings
	// ------------------------------
	// configuration FSM, one map write per strobe.
	typedef enum logic [1:0] {
		cfg_idle,
		cfg_write,
		cfg_ack
	} cfg_state_t;

	// access FSM, map check then one SRAM cycle.
	typedef enum logic [2:0] {
		acc_idle,
		acc_map,
		acc_read,
		acc_write,
		acc_ok
	} acc_state_t;

endpackage

// ==== rtl/mem_settings.svh ====
/*
	Memory unit widths and fixed-segment count.
	Shared by the package and every RTL block.
*/

`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// ------------------------------
// bus and map widths
// ------------------------------
`define MEM_WORD_W     16 // bus data word.
`define MEM_SEG_W      8  // block number + segment bits, also map entry width.
`define MEM_OFFSET_W   12 // word offset inside a 4K segment.

// ------------------------------
// SRAM side
// ------------------------------
`define MEM_SRAM_AW    18 // 256K words of external SRAM.
`define MEM_PAGE_W     6  // low map bits that select the SRAM page.

// segments 0 and 1 are hardwired to physical 0 and 1.
`define MEM_FIXED_SEGS 2

`endif
